// File: design/control_unit.sv
`timescale 1ns/100ps
`include "cu_cfg.svh"

module control_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stop,
    input  logic                        con_ff,
    input  logic [`CU_WORD_WIDTH-1:0]   ir,
    output logic clr, inport_out, read, ram_write,
    output logic hi_enable, lo_enable, con_enable, pc_enable,
    output logic ir_enable, y_enable, z_enable, mar_enable,
    output logic mdr_enable, outport_enable, c_out, ba_out,
    output logic hi_out, lo_out, zhi_out, zlo_out,
    output logic mdr_out, pc_out, pc_increment, y_clr,
    output logic ir_clr, r15_enable,
    output logic [`CU_REG_COUNT-1:0]    reg_in,
    output logic [`CU_REG_COUNT-1:0]    reg_out,
    output logic [`CU_WORD_WIDTH-1:0]   c_sign_extended,
    output logic                        halted
);
    import cu_pkg::*;

    state_e state;
    logic   phase;
    logic   gra, grb, grc, r_in, r_out;    // field selects, decoded below

    step_sequencer step_sequencer_inst (
        .clk    (clk),
        .reset  (reset),
        .stop   (stop),
        .ir     (ir),
        .state  (state),
        .phase  (phase),
        .halted (halted)
    );

    control_word_gen control_word_gen_inst (
        .state(state), .phase(phase), .con_ff(con_ff),
        .clr(clr), .inport_out(inport_out), .read(read), .ram_write(ram_write),
        .hi_enable(hi_enable), .lo_enable(lo_enable), .con_enable(con_enable),
        .pc_enable(pc_enable), .ir_enable(ir_enable), .y_enable(y_enable),
        .z_enable(z_enable), .mar_enable(mar_enable), .mdr_enable(mdr_enable),
        .outport_enable(outport_enable), .c_out(c_out), .ba_out(ba_out),
        .hi_out(hi_out), .lo_out(lo_out), .zhi_out(zhi_out), .zlo_out(zlo_out),
        .mdr_out(mdr_out), .pc_out(pc_out), .pc_increment(pc_increment),
        .y_clr(y_clr), .ir_clr(ir_clr), .r15_enable(r15_enable),
        .gra(gra), .grb(grb), .grc(grc), .r_in(r_in), .r_out(r_out)
    );

    select_encode select_encode_inst (
        .ir              (ir),
        .gra             (gra),
        .grb             (grb),
        .grc             (grc),
        .r_in            (r_in),
        .r_out           (r_out),
        .ba_out          (ba_out),
        .reg_in          (reg_in),
        .reg_out         (reg_out),
        .c_sign_extended (c_sign_extended)
    );

endmodule

// File: design/control_word_gen.sv
`timescale 1ns/100ps

module control_word_gen (
    input  cu_pkg::state_e state,
    input  logic           phase,
    input  logic           con_ff,
    output logic           clr,
    output logic           inport_out,
    output logic           read,
    output logic           ram_write,
    output logic           hi_enable,
    output logic           lo_enable,
    output logic           con_enable,
    output logic           pc_enable,
    output logic           ir_enable,
    output logic           y_enable,
    output logic           z_enable,
    output logic           mar_enable,
    output logic           mdr_enable,
    output logic           outport_enable,
    output logic           c_out,
    output logic           ba_out,
    output logic           hi_out,
    output logic           lo_out,
    output logic           zhi_out,
    output logic           zlo_out,
    output logic           mdr_out,
    output logic           pc_out,
    output logic           pc_increment,
    output logic           y_clr,
    output logic           ir_clr,
    output logic           r15_enable,
    output logic           gra,
    output logic           grb,
    output logic           grc,
    output logic           r_in,
    output logic           r_out
);
    import cu_pkg::*;

    always_comb begin
        {clr, inport_out, read, ram_write, hi_enable, lo_enable, con_enable,
         pc_enable, ir_enable, y_enable, z_enable, mar_enable, mdr_enable,
         outport_enable, c_out, ba_out, hi_out, lo_out, zhi_out, zlo_out,
         mdr_out, pc_out, pc_increment, y_clr, ir_clr, r15_enable,
         gra, grb, grc, r_in, r_out} = '0;

        if (phase == 1'b0) begin
            case (state)
                reset_state: clr = 1'b1;
                fetch0: begin
                    pc_out       = 1'b1;
                    mar_enable   = 1'b1;
                    pc_increment = 1'b1;
                    ir_clr       = 1'b1;
                    y_clr        = 1'b1;
                end
                fetch1: begin
                    read       = 1'b1;
                    mdr_enable = 1'b1;
                    pc_enable  = 1'b1;   // incremented pc back from z
                    zlo_out    = 1'b1;
                end
                fetch2: begin
                    mdr_out   = 1'b1;
                    ir_enable = 1'b1;
                end
                ld3, ldi3, st3: begin   // base register into y
                    grb      = 1'b1;
                    ba_out   = 1'b1;
                    y_enable = 1'b1;
                end
                ld4, ldi4, addi_andi_ori4, st4, br5: begin
                    c_out    = 1'b1;
                    z_enable = 1'b1;
                end
                ld5, st5: begin         // effective address to mar
                    zlo_out    = 1'b1;
                    mar_enable = 1'b1;
                end
                ld6: begin
                    read       = 1'b1;
                    mdr_enable = 1'b1;
                end
                ld7: begin
                    mdr_out = 1'b1;
                    gra     = 1'b1;
                    r_in    = 1'b1;
                end
                ldi5, add_sub5, addi_andi_ori5, neg_not4, ror_rol5, sh5, and_or5: begin
                    zlo_out = 1'b1;     // alu result into ra
                    gra     = 1'b1;
                    r_in    = 1'b1;
                end
                br3: begin
                    gra        = 1'b1;
                    r_out      = 1'b1;
                    con_enable = 1'b1;
                end
                br4: begin
                    pc_out   = 1'b1;
                    y_enable = 1'b1;
                end
                br6: begin
                    zlo_out   = 1'b1;
                    pc_enable = con_ff;  // target taken only on condition
                end
                add_sub3, addi_andi_ori3, ror_rol3, sh3, and_or3: begin
                    grb      = 1'b1;
                    r_out    = 1'b1;
                    y_enable = 1'b1;
                end
                add_sub4, ror_rol4, sh4, and_or4: begin
                    grc      = 1'b1;
                    r_out    = 1'b1;
                    z_enable = 1'b1;
                end
                neg_not3, mul4, div4: begin
                    grb      = 1'b1;
                    r_out    = 1'b1;
                    z_enable = 1'b1;
                end
                st6: begin              // stored value from ra
                    gra        = 1'b1;
                    r_out      = 1'b1;
                    mdr_enable = 1'b1;
                end
                st7: ram_write = 1'b1;
                mul3, div3: begin
                    gra      = 1'b1;
                    r_out    = 1'b1;
                    y_enable = 1'b1;
                end
                mul5, div5: begin
                    zlo_out   = 1'b1;
                    lo_enable = 1'b1;
                end
                mul6, div6: begin
                    zhi_out   = 1'b1;
                    hi_enable = 1'b1;
                end
                mfhi3: begin
                    hi_out = 1'b1;
                    gra    = 1'b1;
                    r_in   = 1'b1;
                end
                mflo3: begin
                    lo_out = 1'b1;
                    gra    = 1'b1;
                    r_in   = 1'b1;
                end
                jal3: begin             // return address into r15
                    pc_out     = 1'b1;
                    r15_enable = 1'b1;
                end
                jal4, jr3: begin
                    gra       = 1'b1;
                    r_out     = 1'b1;
                    pc_enable = 1'b1;
                end
                in3: begin
                    inport_out = 1'b1;
                    gra        = 1'b1;
                    r_in       = 1'b1;
                end
                out3: begin
                    outport_enable = 1'b1;
                    gra            = 1'b1;
                    r_out          = 1'b1;
                end
                default: ;              // nop3, spares and halt drive nothing
            endcase
        end else if (state == fetch0) begin
            // only fetch0 has a phase 1 word, pc + 1 into z
            pc_out   = 1'b1;
            z_enable = 1'b1;
        end
    end

    // one register field on the bus at a time
    always_comb begin
        assert ($onehot0({gra, grb, grc}))
            else $error("more than one register field selected");
        assert (!(r_in && r_out))
            else $error("register read and write in the same cycle");
    end

endmodule

// File: design/cu_cfg.svh
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// instruction set widths, all fixed by the ISA

// instruction and data word
`define CU_WORD_WIDTH       32

// opcode field, top of the word
`define CU_OPCODE_WIDTH     5

// general register file
`define CU_REG_COUNT        16
`define CU_REG_INDEX_WIDTH  4

// immediate field of the i-format
`define CU_IMM_WIDTH        19

// sequencer state encoding
`define CU_STATE_WIDTH      6

`endif

// File: design/cu_pkg.sv
`include "cu_cfg.svh"

package cu_pkg;

    // opcodes as encoded in ir[31:27]
    typedef enum logic [`CU_OPCODE_WIDTH-1:0] {
        op_ld = 5'd0, op_ldi, op_st, op_add, op_sub,
        op_shr, op_shra, op_shl, op_ror, op_rol,
        op_and, op_or, op_addi, op_andi, op_ori,
        op_mul, op_div, op_neg, op_not, op_br,
        op_jr, op_jal, op_in, op_out, op_mfhi,
        op_mflo, op_nop    // 26, codes 27 to 31 undefined
    } opcode_e;

    // each state is held for two cycles, phase 0 then phase 1
    typedef enum logic [`CU_STATE_WIDTH-1:0] {
        reset_state = 6'd0,
        fetch0, fetch1, fetch2,
        ld3, ld4, ld5, ld6, ld7,
        ldi3, ldi4, ldi5,
        br3, br4, br5, br6,
        nop3,
        add_sub3, add_sub4, add_sub5,
        addi_andi_ori3, addi_andi_ori4, addi_andi_ori5,
        neg_not3, neg_not4,
        andi3, andi4,              // spare, not dispatched
        ror_rol3, ror_rol4, ror_rol5,
        sh3, sh4, sh5,
        st3, st4, st5, st6, st7,
        and_or3, and_or4, and_or5,
        mul3, mul4, mul5, mul6,
        mfhi3, mflo3,
        div3, div4, div5, div6,
        jal3, jal4,
        jr3, in3, out3,
        halt_state                 // parked here after stop
    } state_e;

    // three-register view
    typedef struct packed {
        logic [`CU_OPCODE_WIDTH-1:0]    opcode;
        logic [`CU_REG_INDEX_WIDTH-1:0] ra;
        logic [`CU_REG_INDEX_WIDTH-1:0] rb;
        logic [`CU_REG_INDEX_WIDTH-1:0] rc;
        logic [`CU_WORD_WIDTH-`CU_OPCODE_WIDTH-3*`CU_REG_INDEX_WIDTH-1:0] unused;
    } r_format_s;

    // two registers plus constant
    typedef struct packed {
        logic [`CU_OPCODE_WIDTH-1:0]    opcode;
        logic [`CU_REG_INDEX_WIDTH-1:0] ra;
        logic [`CU_REG_INDEX_WIDTH-1:0] rb;
        logic [`CU_IMM_WIDTH-1:0]       c;
    } i_format_s;

    // same instruction word, read as either format
    typedef union packed {
        r_format_s r_fmt;
        i_format_s i_fmt;
    } ir_word_u;

endpackage

// File: design/select_encode.sv
`timescale 1ns/100ps
`include "cu_cfg.svh"

module select_encode (
    input  cu_pkg::ir_word_u            ir,
    input  logic                        gra,
    input  logic                        grb,
    input  logic                        grc,
    input  logic                        r_in,
    input  logic                        r_out,
    input  logic                        ba_out,
    output logic [`CU_REG_COUNT-1:0]    reg_in,
    output logic [`CU_REG_COUNT-1:0]    reg_out,
    output logic [`CU_WORD_WIDTH-1:0]   c_sign_extended
);
    logic [`CU_REG_INDEX_WIDTH-1:0] reg_sel;     // chosen register field
    logic [`CU_REG_COUNT-1:0]       reg_onehot;

    // register view of the word
    always_comb begin
        if (gra) begin
            reg_sel = ir.r_fmt.ra;
        end else if (grb) begin
            reg_sel = ir.r_fmt.rb;
        end else if (grc) begin
            reg_sel = ir.r_fmt.rc;
        end else begin
            reg_sel = '0;
        end
    end

    always_comb begin
        reg_onehot = '0;
        reg_onehot[reg_sel] = 1'b1;
    end

    assign reg_in  = r_in ? reg_onehot : '0;
    assign reg_out = (r_out || ba_out) ? reg_onehot : '0;   // ba_out reads rb as base

    // immediate view, constant widened to a full word
    assign c_sign_extended = {
        {(`CU_WORD_WIDTH - `CU_IMM_WIDTH){ir.i_fmt.c[`CU_IMM_WIDTH-1]}},
        ir.i_fmt.c
    };

    // at most one register written per cycle
    always_comb begin
        assert ($onehot0(reg_in))
            else $error("reg_in has more than one enable");
    end

endmodule

// File: design/step_sequencer.sv
`timescale 1ns/100ps

module step_sequencer (
    input  logic             clk,
    input  logic             reset,
    input  logic             stop,
    input  cu_pkg::ir_word_u ir,
    output cu_pkg::state_e   state,
    output logic             phase,
    output logic             halted
);
    import cu_pkg::*;

    state_e next_state;
    logic   instr_end;    // state is the last one of an instruction

    // successor of the current state, stop not yet applied
    always_comb begin
        case (state)
            reset_state: next_state = fetch0;
            fetch0:      next_state = fetch1;
            fetch1:      next_state = fetch2;
            fetch2: begin
                // opcode dispatch
                case (opcode_e'(ir.r_fmt.opcode))
                    op_ld:                  next_state = ld3;
                    op_ldi:                 next_state = ldi3;
                    op_br:                  next_state = br3;
                    op_add, op_sub:         next_state = add_sub3;
                    op_addi, op_andi,
                    op_ori:                 next_state = addi_andi_ori3;
                    op_neg, op_not:         next_state = neg_not3;
                    op_ror, op_rol:         next_state = ror_rol3;
                    op_shr, op_shra,
                    op_shl:                 next_state = sh3;
                    op_st:                  next_state = st3;
                    op_and, op_or:          next_state = and_or3;
                    op_mul:                 next_state = mul3;
                    op_div:                 next_state = div3;
                    op_mfhi:                next_state = mfhi3;
                    op_mflo:                next_state = mflo3;
                    op_jal:                 next_state = jal3;
                    op_jr:                  next_state = jr3;
                    op_in:                  next_state = in3;
                    op_out:                 next_state = out3;
                    default:                next_state = nop3;   // nop and codes 27 to 31
                endcase
            end
            ld3:            next_state = ld4;
            ld4:            next_state = ld5;
            ld5:            next_state = ld6;
            ld6:            next_state = ld7;
            ldi3:           next_state = ldi4;
            ldi4:           next_state = ldi5;
            br3:            next_state = br4;
            br4:            next_state = br5;
            br5:            next_state = br6;
            add_sub3:       next_state = add_sub4;
            add_sub4:       next_state = add_sub5;
            addi_andi_ori3: next_state = addi_andi_ori4;
            addi_andi_ori4: next_state = addi_andi_ori5;
            neg_not3:       next_state = neg_not4;
            ror_rol3:       next_state = ror_rol4;
            ror_rol4:       next_state = ror_rol5;
            sh3:            next_state = sh4;
            sh4:            next_state = sh5;
            st3:            next_state = st4;
            st4:            next_state = st5;
            st5:            next_state = st6;
            st6:            next_state = st7;
            and_or3:        next_state = and_or4;
            and_or4:        next_state = and_or5;
            mul3:           next_state = mul4;
            mul4:           next_state = mul5;
            mul5:           next_state = mul6;
            div3:           next_state = div4;
            div4:           next_state = div5;
            div5:           next_state = div6;
            jal3:           next_state = jal4;
            halt_state:     next_state = halt_state;
            // ld7, ldi5, br6, nop3 and every other final state
            default:        next_state = fetch0;
        endcase
    end

    // reset_state also returns to fetch0 but ends no instruction
    assign instr_end = (next_state == fetch0) && (state != reset_state);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= reset_state;
            phase <= 1'b0;
        end else begin
            phase <= ~phase;
            if (phase) begin    // step only at the end of phase 1
                state <= (stop && instr_end) ? halt_state : next_state;
            end
        end
    end

    assign halted = (state == halt_state);

    // two-cycle step holds for the whole run, halt included
    assert property (@(posedge clk) disable iff (reset)
        !reset |=> phase != $past(phase))
        else $error("phase did not toggle");

    // only reset leaves the halt state
    assert property (@(posedge clk) disable iff (reset)
        state == halt_state |=> state == halt_state)
        else $error("left halt_state without reset");

endmodule

// File: files.f
+incdir+design
design/cu_pkg.sv
design/step_sequencer.sv
design/control_word_gen.sv
design/select_encode.sv
design/control_unit.sv
tb/tb_control_unit.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, pass only when the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_control_unit -o sim_tb \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -qx "Result: PASSED" && exit 0 || exit 1

// File: tb/cu_stimulus.txt
// columns, all hex: ir con_ff stop cycles write_reg(F = none) pc_enable_cycles c_sign_extended
// stop line goes last, the unit parks in halt_state after it
01180010 0 0 10 2 1 00000010  // ld r2, 0x10(r3)
0A07FFFB 0 0 0C 4 1 FFFFFFFB  // ldi r4, -5
0A8BFFFF 0 0 0C 5 1 0003FFFF  // ldi r5, largest positive
10900020 0 0 10 F 1 00000020  // st
1B3C0000 0 0 0C 6 1 FFFC0000  // add r6, r7, r8
21890000 0 0 0C 3 1 00010000  // sub
2CC88000 0 0 0C 9 1 00008000  // shr
35118000 0 0 0C A 1 00018000  // shra
3D800000 0 0 0C B 1 00000000  // shl
460A0000 0 0 0C C 1 00020000  // ror
4E928000 0 0 0C D 1 00028000  // rol
571B0000 0 0 0C E 1 00030000  // and
58090000 0 0 0C 0 1 00010000  // or into r0
6097FFFF 0 0 0C 1 1 FFFFFFFF  // addi, -1
61180123 0 0 0C 2 1 00000123  // addi, positive
69A000FF 0 0 0C 3 1 000000FF  // andi
722C0001 0 0 0C 4 1 FFFC0001  // ori, negative constant
7AB00000 0 0 0E F 1 00000000  // mul
83C00000 0 0 0E F 1 00000000  // div
8C480000 0 0 0A 8 1 00000000  // neg
94D00000 0 0 0A 9 1 00000000  // not
98800010 0 0 0E F 1 00000010  // br, not taken
9907FFF0 1 0 0E F 2 FFFFFFF0  // br, taken
A1800000 0 0 08 F 2 00000000  // jr
AA000000 0 0 0A F 2 00000000  // jal
B2800000 0 0 08 5 1 00000000  // in
BB000000 0 0 08 F 1 00000000  // out
C3800000 0 0 08 7 1 00000000  // mfhi
CC000000 0 0 08 8 1 00000000  // mflo
D0000000 0 0 08 F 1 00000000  // nop
D8000000 0 0 08 F 1 00000000  // opcode 27
F8000000 0 1 08 F 1 00000000  // opcode 31, then halt

// File: tb/tb_control_unit.sv
`timescale 1ns/100ps
`include "cu_cfg.svh"

module tb_control_unit;

    localparam int         FIELDS         = 7;      // columns per stimulus line
    localparam int         MAX_LINES      = 40;
    localparam int         RESET_CYCLES   = 16;
    localparam int         HALT_WATCH     = 20;
    localparam int         TIMEOUT_MARGIN = 64;
    localparam logic [3:0] NO_WRITE       = 4'hF;   // register column when nothing is written

    logic                        clk;
    logic                        reset;
    logic                        stop;
    logic                        con_ff;
    logic [`CU_WORD_WIDTH-1:0]   ir;
    logic clr, inport_out, read, ram_write;
    logic hi_enable, lo_enable, con_enable, pc_enable;
    logic ir_enable, y_enable, z_enable, mar_enable;
    logic mdr_enable, outport_enable, c_out, ba_out;
    logic hi_out, lo_out, zhi_out, zlo_out;
    logic mdr_out, pc_out, pc_increment, y_clr;
    logic ir_clr, r15_enable;
    logic [`CU_REG_COUNT-1:0]    reg_in;
    logic [`CU_REG_COUNT-1:0]    reg_out;
    logic [`CU_WORD_WIDTH-1:0]   c_sign_extended;
    logic                        halted;
    logic                        other_strobes;     // everything but clr

    logic [31:0] stim_mem [0:FIELDS*MAX_LINES-1];
    int          num_lines;
    int          test_count;
    int          check_count;
    int          error_count;
    int          cycle_count;
    int          timeout_limit;
    int          last_ir_enable;    // cycle_count at the previous ir_enable

    control_unit control_unit_inst (.*);

    assign other_strobes = inport_out | read | ram_write | hi_enable | lo_enable
        | con_enable | pc_enable | ir_enable | y_enable | z_enable | mar_enable
        | mdr_enable | outport_enable | c_out | ba_out | hi_out | lo_out | zhi_out
        | zlo_out | mdr_out | pc_out | pc_increment | y_clr | ir_clr | r15_enable
        | (|reg_in) | (|reg_out);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run length bound, counted from reset release
    always @(posedge clk) begin
        if (!reset) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > timeout_limit) begin
                $display("timeout: the control unit stopped advancing after %0d cycles",
                         cycle_count);
                $display("Result: FAILED");
                $finish;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic report_test(input string label, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", label);
        end else begin
            $display("test %s: %0d failed checks", label, error_count - errors_before);
        end
    endtask

    // clr for one cycle in reset_state, then silence until fetch0
    task automatic check_reset_pulse();
        int clr_cycles;
        int busy_cycles;
        int errors_before;
        clr_cycles    = 0;
        busy_cycles   = 0;
        errors_before = error_count;
        @(negedge clk);
        while (!pc_increment) begin
            if (clr) clr_cycles++;
            if (other_strobes) busy_cycles++;
            @(negedge clk);
        end
        check_value("clr cycles", clr_cycles, 1);
        check_value("strobe cycles before fetch0", busy_cycles, 0);
        report_test("reset clear pulse", errors_before);
    endtask

    // entered just after the fetch0 phase 0 sample of this instruction
    task automatic run_instruction(input int index, output logic halt_seen);
        logic [31:0]              word;
        logic                     exp_con;
        logic                     exp_stop;
        int                       exp_cycles;
        logic [3:0]               exp_reg;
        int                       exp_pc_en;
        logic [31:0]              exp_c;
        int                       cycles;
        int                       write_cycles;
        logic [`CU_REG_COUNT-1:0] write_value;
        int                       pc_en_cycles;
        int                       ir_en_cycles;
        int                       halt_fetches;
        int                       errors_before;
        word          = stim_mem[index*FIELDS];
        exp_con       = stim_mem[index*FIELDS+1][0];
        exp_stop      = stim_mem[index*FIELDS+2][0];
        exp_cycles    = int'(stim_mem[index*FIELDS+3]);
        exp_reg       = stim_mem[index*FIELDS+4][3:0];
        exp_pc_en     = int'(stim_mem[index*FIELDS+5]);
        exp_c         = stim_mem[index*FIELDS+6];
        errors_before = error_count;
        cycles        = 1;      // fetch0 phase 0 already seen
        write_cycles  = 0;
        write_value   = '0;
        pc_en_cycles  = 0;
        ir_en_cycles  = 0;
        halt_fetches  = 0;

        // word held from fetch0 phase 1, long before the opcode is sampled
        @(posedge clk);
        ir     <= word;
        con_ff <= exp_con;
        stop   <= exp_stop;

        // fetch0 to fetch0
        @(negedge clk);
        while (!pc_increment && !halted) begin
            cycles++;
            if (reg_in != '0) begin
                write_cycles++;
                write_value = reg_in;
            end
            if (pc_enable) pc_en_cycles++;
            if (ir_enable) begin
                ir_en_cycles++;
                // previous instruction's length, load to load
                if (index > 0) begin
                    check_value("ir_enable spacing", cycle_count - last_ir_enable,
                                stim_mem[(index-1)*FIELDS+3]);
                end
                last_ir_enable = cycle_count;
                check_value("c_sign_extended", c_sign_extended, exp_c);
            end
            @(negedge clk);
        end

        check_value("cycles", cycles, exp_cycles);
        check_value("ir_enable cycles", ir_en_cycles, 1);
        check_value("reg_in cycles", write_cycles, (exp_reg == NO_WRITE) ? 0 : 1);
        check_value("reg_in", 32'(write_value),
                    (exp_reg == NO_WRITE) ? 32'd0 : (32'd1 << exp_reg));
        check_value("pc_enable cycles", pc_en_cycles, exp_pc_en);
        check_value("halted", 32'(halted), 32'(exp_stop));

        halt_seen = halted;
        if (halted) begin
            repeat (HALT_WATCH) begin
                @(negedge clk);
                if (ir_enable) halt_fetches++;
            end
            check_value("ir_enable cycles while halted", halt_fetches, 0);
            check_value("halted after watch", 32'(halted), 32'd1);
        end
        report_test($sformatf("line %0d, ir %h", index, word), errors_before);
    endtask

    initial begin
        int   total_cycles;
        int   line;
        logic halt_seen;
        reset          = 1'b1;
        stop           = 1'b0;
        con_ff         = 1'b0;
        ir             = '0;
        num_lines      = 0;
        test_count     = 0;
        check_count    = 0;
        error_count    = 0;
        cycle_count    = 0;
        last_ir_enable = 0;
        total_cycles   = 0;
        halt_seen      = 1'b0;
        line           = 0;

        for (int n = 0; n < FIELDS*MAX_LINES; n++) begin
            stim_mem[n] = '0;
        end
        $readmemh("tb/cu_stimulus.txt", stim_mem);
        // a zero cycle count marks the end of the table
        while (num_lines < MAX_LINES && stim_mem[num_lines*FIELDS+3] != 0) begin
            total_cycles += int'(stim_mem[num_lines*FIELDS+3]);
            num_lines++;
        end
        timeout_limit = total_cycles + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        check_reset_pulse();

        while (line < num_lines && !halt_seen) begin
            run_instruction(line, halt_seen);
            line++;
        end
        if (num_lines == 0) begin
            $display("no stimulus lines were read");
            error_count++;
        end else if (line < num_lines) begin
            $display("stimulus lines after the halt were never run");
            error_count++;
        end

        $display("tests %0d, checks %0d, failed checks %0d",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
